// File: logic/machine_mode_types_pkg.sv
package machine_mode_types_pkg;

  // Plain 32-bit CSR payload, used for mepc and mbadaddr.
  typedef logic [31:0] word_t;

  // Machine status word. Only the global interrupt enable is implemented.
  typedef struct packed {
    logic [30:0] reserved; // Always reads as zero.
    logic        ie;       // Global machine interrupt enable.
  } mstatus_t;

  // Machine interrupt enable.
  typedef struct packed {
    logic [23:0] reserved_hi; // Bits 31:8.
    logic        mtie;        // Timer interrupt enable, bit 7.
    logic [2:0]  reserved_mid;
    logic        msie;        // Software interrupt enable, bit 3.
    logic [2:0]  reserved_lo;
  } mie_t;

  // Machine interrupt pending, same layout as mie.
  typedef struct packed {
    logic [23:0] reserved_hi;
    logic        mtip;        // Timer interrupt pending.
    logic [2:0]  reserved_mid;
    logic        msip;        // Software (and external) interrupt pending.
    logic [2:0]  reserved_lo;
  } mip_t;

  // Trap cause.
  typedef struct packed {
    logic        interrupt; // Set for interrupts, clear for exceptions.
    logic [30:0] cause;     // Exception or interrupt code.
  } mcause_t;

  // Synchronous exception codes.
  typedef enum logic [30:0] {
    INSN_MAL     = 31'd0,
    INSN_FAULT   = 31'd1,
    ILLEGAL_INSN = 31'd2,
    BREAKPOINT   = 31'd3,
    L_ADDR_MAL   = 31'd4,
    L_FAULT      = 31'd5,
    S_ADDR_MAL   = 31'd6,
    S_FAULT      = 31'd7,
    ENV_CALL_M   = 31'd11
  } ex_code_t;

  // Interrupt codes.
  typedef enum logic [30:0] {
    SOFT_INT  = 31'd3,
    TIMER_INT = 31'd7,
    EXT_INT   = 31'd11
  } int_code_t;

  // Implemented CSR addresses.
  typedef enum logic [11:0] {
    MSTATUS  = 12'h300,
    MIE      = 12'h304,
    MEPC     = 12'h341,
    MCAUSE   = 12'h342,
    MBADADDR = 12'h343,
    MIP      = 12'h344,
    MTIME    = 12'h701,
    MTIMECMP = 12'h7C1
  } csr_addr_t;

endpackage

// File: logic/prv_pipe_pkg.sv
package prv_pipe_pkg;
  import machine_mode_types_pkg::*;

  // Exception flags reported by the pipeline stages.
  typedef struct packed {
    logic fault_l;      // Load access fault.
    logic mal_l;        // Load address misaligned.
    logic fault_s;      // Store access fault.
    logic mal_s;        // Store address misaligned.
    logic breakpoint;
    logic env_m;        // ECALL from machine mode.
    logic illegal_insn;
    logic fault_insn;   // Instruction access fault.
    logic mal_insn;     // Instruction address misaligned.
  } pipe_event_t;

  // Software CSR access.
  typedef struct packed {
    logic      wen;
    logic      ren;
    csr_addr_t addr;
    logic [31:0] wdata;
  } csr_req_t;

  // Hardware updates from trap control into the CSR file.
  typedef struct packed {
    logic     mstatus_rup;
    mstatus_t mstatus_next;
    logic     mip_rup;
    mip_t     mip_next;
    logic     mcause_rup;
    mcause_t  mcause_next;
    logic     mepc_rup;
    word_t    mepc_next;
    logic     mbadaddr_rup;
    word_t    mbadaddr_next;
  } csr_upd_t;

  // Current CSR state seen by trap control.
  typedef struct packed {
    mstatus_t mstatus;
    mie_t     mie;
    mip_t     mip;
  } csr_state_t;

endpackage

// File: logic/csr_reg.sv
`timescale 1ns/10ps

// Single machine CSR. Hardware update beats a software write.
module csr_reg #(
  parameter type  reg_t     = logic [31:0],
  parameter reg_t RESET_VAL = '0
) (
  input  logic CLK,
  input  logic nRST,
  input  logic wen,   // Software write strobe.
  input  reg_t wdata, // Software write value, already masked.
  input  logic rup,   // Hardware update request.
  input  reg_t next,  // Hardware update value.
  output reg_t q
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q <= RESET_VAL;
    end else if (rup) begin
      q <= next; // Trap side has priority.
    end else if (wen) begin
      q <= wdata;
    end
  end

endmodule

// File: logic/prv_timer.sv
`timescale 1ns/10ps

// Machine timer. Free-running mtime with a software-written compare value.
module prv_timer #(
  parameter int TIMER_WIDTH = 32
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   cmp_wen,   // CSR write to MTIMECMP.
  input  logic [31:0]            cmp_wdata,
  output logic [TIMER_WIDTH-1:0] mtime,
  output logic [TIMER_WIDTH-1:0] mtimecmp,
  output logic                   timer_int,      // One cycle on compare match.
  output logic                   clear_timer_int // Compare register rewritten.
);

  // Counts every cycle and wraps silently.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + TIMER_WIDTH'(1);
    end
  end

  // Compare value resets to all ones so no match occurs early.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mtimecmp <= '1;
    end else if (cmp_wen) begin
      mtimecmp <= cmp_wdata[TIMER_WIDTH-1:0]; // Upper bits dropped for narrow timers.
    end
  end

  // Match lasts one cycle since mtime keeps moving.
  assign timer_int = (mtime == mtimecmp);

  // Any rewrite of the compare value retires the pending timer interrupt.
  assign clear_timer_int = cmp_wen;

endmodule

// File: logic/prv_control.sv
`timescale 1ns/10ps

// Trap control. Picks the trap source and drives CSR updates.
module prv_control import machine_mode_types_pkg::*, prv_pipe_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  pipe_event_t pipe_ev,
  input  logic        ret,        // Return from trap.
  input  logic        pipe_clear, // Pipeline drained, trap taken.
  input  logic [31:0] epc,
  input  logic [31:0] badaddr,
  input  logic        soft_int,
  input  logic        ext_int,
  input  logic        timer_int,
  input  logic        clear_timer_int,
  input  csr_state_t  csr_state,
  output logic        intr,
  output csr_upd_t    csr_upd
);

  ex_code_t  ex_src;
  logic      exception;
  int_code_t intr_src;
  logic      int_fire;  // Enabled interrupt pending this cycle.
  logic      int_latch; // Held until the pipeline drains.
  logic      bad_flag;  // Flags that report a bad address.

  // Exception priority, load side first.
  always_comb begin
    exception = 1'b1;
    ex_src    = INSN_MAL;
    if (pipe_ev.fault_l)           ex_src = L_FAULT;
    else if (pipe_ev.mal_l)        ex_src = L_ADDR_MAL;
    else if (pipe_ev.fault_s)      ex_src = S_FAULT;
    else if (pipe_ev.mal_s)        ex_src = S_ADDR_MAL;
    else if (pipe_ev.breakpoint)   ex_src = BREAKPOINT;
    else if (pipe_ev.env_m)        ex_src = ENV_CALL_M;
    else if (pipe_ev.illegal_insn) ex_src = ILLEGAL_INSN;
    else if (pipe_ev.fault_insn)   ex_src = INSN_FAULT;
    else if (pipe_ev.mal_insn)     ex_src = INSN_MAL;
    else                           exception = 1'b0;
  end

  // Interrupt cause from the pending and enabled bits.
  // External interrupts share msip and so report the soft code.
  always_comb begin
    if (csr_state.mip.mtip && csr_state.mie.mtie) begin
      intr_src = TIMER_INT;
    end else begin
      intr_src = SOFT_INT;
    end
  end

  assign int_fire = csr_state.mstatus.ie &
                    ((csr_state.mie.mtie & csr_state.mip.mtip) |
                     (csr_state.mie.msie & csr_state.mip.msip));

  assign intr = exception | int_latch; // To pipeline, combinational.

  assign bad_flag = pipe_ev.fault_l | pipe_ev.mal_l | pipe_ev.fault_s | pipe_ev.mal_s |
                    pipe_ev.illegal_insn | pipe_ev.fault_insn | pipe_ev.mal_insn;

  always_comb begin
    csr_upd = '0;

    // Pending bits. The clear strobe wins over a same-cycle match.
    csr_upd.mip_rup  = timer_int | soft_int | ext_int | clear_timer_int;
    csr_upd.mip_next = csr_state.mip;
    if (timer_int)       csr_upd.mip_next.mtip = 1'b1;
    if (clear_timer_int) csr_upd.mip_next.mtip = 1'b0;
    if (soft_int)        csr_upd.mip_next.msip = 1'b1;
    if (ext_int)         csr_upd.mip_next.msip = 1'b1;

    // Cause is an exception whenever one is present.
    csr_upd.mcause_rup = exception | int_fire;
    csr_upd.mcause_next.interrupt = ~exception;
    if (exception) begin
      csr_upd.mcause_next.cause = ex_src;
    end else begin
      csr_upd.mcause_next.cause = intr_src;
    end

    // Global enable drops while trapping and comes back on return.
    csr_upd.mstatus_rup = intr | int_fire | ret;
    if (intr)     csr_upd.mstatus_next.ie = 1'b0;
    else if (ret) csr_upd.mstatus_next.ie = 1'b1;
    else          csr_upd.mstatus_next.ie = csr_state.mstatus.ie;

    csr_upd.mepc_rup  = exception | (int_latch & pipe_clear);
    csr_upd.mepc_next = epc;

    csr_upd.mbadaddr_rup  = bad_flag & pipe_clear;
    csr_upd.mbadaddr_next = badaddr;
  end

  // Firing lasts only until ie drops, so hold it until the pipeline is clear.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      int_latch <= 1'b0;
    end else if (int_fire) begin
      int_latch <= 1'b1;
    end else if (pipe_clear) begin
      int_latch <= 1'b0;
    end
  end

endmodule

// File: logic/prv_csr_file.sv
`timescale 1ns/10ps

// Machine CSR storage, software access decode and read mux.
module prv_csr_file import machine_mode_types_pkg::*, prv_pipe_pkg::*; #(
  parameter int TIMER_WIDTH = 32
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  csr_req_t               csr_req,
  input  csr_upd_t               csr_upd,
  input  logic [TIMER_WIDTH-1:0] mtime,
  input  logic [TIMER_WIDTH-1:0] mtimecmp,
  output csr_state_t             csr_state,
  output logic                   cmp_wen,
  output logic [31:0]            cmp_wdata,
  output logic [31:0]            csr_rdata
);

  logic     mstatus_wen, mie_wen, mcause_wen, mepc_wen, mbadaddr_wen;
  mstatus_t mstatus_wdata;
  mie_t     mie_wdata;
  mstatus_t mstatus_q;
  mie_t     mie_q;
  mip_t     mip_q;
  mcause_t  mcause_q;
  word_t    mepc_q;
  word_t    mbadaddr_q;

  // Per-register write enables. MIP has none, it is read only.
  always_comb begin
    mstatus_wen  = 1'b0;
    mie_wen      = 1'b0;
    mcause_wen   = 1'b0;
    mepc_wen     = 1'b0;
    mbadaddr_wen = 1'b0;
    cmp_wen      = 1'b0;
    if (csr_req.wen) begin
      case (csr_req.addr)
        MSTATUS:  mstatus_wen  = 1'b1;
        MIE:      mie_wen      = 1'b1;
        MCAUSE:   mcause_wen   = 1'b1;
        MEPC:     mepc_wen     = 1'b1;
        MBADADDR: mbadaddr_wen = 1'b1;
        MTIMECMP: cmp_wen      = 1'b1; // Handled by the timer.
        default:  ;
      endcase
    end
  end

  assign cmp_wdata = csr_req.wdata;

  // Keep only implemented bits, reserved fields stay zero.
  always_comb begin
    mstatus_wdata      = '0;
    mstatus_wdata.ie   = csr_req.wdata[0];
    mie_wdata          = '0;
    mie_wdata.mtie     = csr_req.wdata[7];
    mie_wdata.msie     = csr_req.wdata[3];
  end

  csr_reg #(.reg_t(mstatus_t), .RESET_VAL(mstatus_t'('0))) u_mstatus (
    .CLK, .nRST,
    .wen(mstatus_wen), .wdata(mstatus_wdata),
    .rup(csr_upd.mstatus_rup), .next(csr_upd.mstatus_next),
    .q(mstatus_q)
  );

  csr_reg #(.reg_t(mie_t), .RESET_VAL(mie_t'('0))) u_mie (
    .CLK, .nRST,
    .wen(mie_wen), .wdata(mie_wdata),
    .rup(1'b0), .next(mie_t'('0)), // Software only.
    .q(mie_q)
  );

  csr_reg #(.reg_t(mip_t), .RESET_VAL(mip_t'('0))) u_mip (
    .CLK, .nRST,
    .wen(1'b0), .wdata(mip_t'('0)), // Hardware only.
    .rup(csr_upd.mip_rup), .next(csr_upd.mip_next),
    .q(mip_q)
  );

  csr_reg #(.reg_t(mcause_t), .RESET_VAL(mcause_t'('0))) u_mcause (
    .CLK, .nRST,
    .wen(mcause_wen), .wdata(mcause_t'(csr_req.wdata)),
    .rup(csr_upd.mcause_rup), .next(csr_upd.mcause_next),
    .q(mcause_q)
  );

  csr_reg #(.reg_t(word_t), .RESET_VAL(word_t'('0))) u_mepc (
    .CLK, .nRST,
    .wen(mepc_wen), .wdata(csr_req.wdata),
    .rup(csr_upd.mepc_rup), .next(csr_upd.mepc_next),
    .q(mepc_q)
  );

  csr_reg #(.reg_t(word_t), .RESET_VAL(word_t'('0))) u_mbadaddr (
    .CLK, .nRST,
    .wen(mbadaddr_wen), .wdata(csr_req.wdata),
    .rup(csr_upd.mbadaddr_rup), .next(csr_upd.mbadaddr_next),
    .q(mbadaddr_q)
  );

  assign csr_state.mstatus = mstatus_q;
  assign csr_state.mie     = mie_q;
  assign csr_state.mip     = mip_q;

  // Combinational read. Timer values are zero-extended.
  always_comb begin
    csr_rdata = '0;
    if (csr_req.ren) begin
      case (csr_req.addr)
        MSTATUS:  csr_rdata = mstatus_q;
        MIE:      csr_rdata = mie_q;
        MIP:      csr_rdata = mip_q;
        MCAUSE:   csr_rdata = mcause_q;
        MEPC:     csr_rdata = mepc_q;
        MBADADDR: csr_rdata = mbadaddr_q;
        MTIME:    csr_rdata[TIMER_WIDTH-1:0] = mtime;
        MTIMECMP: csr_rdata[TIMER_WIDTH-1:0] = mtimecmp;
        default:  csr_rdata = '0; // Unknown address.
      endcase
    end
  end

endmodule

// File: logic/prv_block.sv
`timescale 1ns/10ps

// Machine-mode privilege unit top level.
module prv_block import prv_pipe_pkg::*; #(
  parameter int TIMER_WIDTH = 32
) (
  input  logic        CLK,
  input  logic        nRST,
  input  pipe_event_t pipe_ev,
  input  logic        ret,
  input  logic        pipe_clear,
  input  logic [31:0] epc,
  input  logic [31:0] badaddr,
  input  logic        soft_int,
  input  logic        ext_int,
  input  csr_req_t    csr_req,
  output logic        intr,
  output logic [31:0] csr_rdata
);

  logic                   timer_int, clear_timer_int;
  logic                   cmp_wen;
  logic [31:0]            cmp_wdata;
  logic [TIMER_WIDTH-1:0] mtime, mtimecmp;
  csr_upd_t               csr_upd;   // Control to CSR file.
  csr_state_t             csr_state; // CSR file to control.

  prv_timer #(.TIMER_WIDTH(TIMER_WIDTH)) u_timer (
    .CLK, .nRST,
    .cmp_wen, .cmp_wdata,
    .mtime, .mtimecmp,
    .timer_int, .clear_timer_int
  );

  prv_control u_control (
    .CLK, .nRST,
    .pipe_ev, .ret, .pipe_clear,
    .epc, .badaddr,
    .soft_int, .ext_int,
    .timer_int, .clear_timer_int,
    .csr_state,
    .intr, .csr_upd
  );

  prv_csr_file #(.TIMER_WIDTH(TIMER_WIDTH)) u_csr (
    .CLK, .nRST,
    .csr_req, .csr_upd,
    .mtime, .mtimecmp,
    .csr_state,
    .cmp_wen, .cmp_wdata,
    .csr_rdata
  );

endmodule

// File: sim/prv_tb_checks.svh
`ifndef PRV_TB_CHECKS_SVH
`define PRV_TB_CHECKS_SVH

// Stop at the first error.
task automatic fail_now(input string what);
  $display("%s", what);
  $display("Test failures found");
  $fatal(1, "Stopping at the first error.");
endtask

// Plain 32-bit compare, used for CSR read data.
task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("FAIL %s: got %h expected %h", name, got, exp);
    fail_now("Word compare mismatch.");
  end
endtask

// Single-bit compare, used for intr and CSR fields.
task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAIL %s: got %h expected %h", name, got, exp);
    fail_now("Bit compare mismatch.");
  end
endtask

// Cause compare. Shows both fields.
task automatic check_mcause(input string name, input mcause_t got, input mcause_t exp);
  if (got !== exp) begin
    $display("FAIL %s: got %h (int %h code %h) expected %h (int %h code %h)",
             name, got, got.interrupt, got.cause, exp, exp.interrupt, exp.cause);
    fail_now("Cause compare mismatch.");
  end
endtask

`endif

// File: sim/prv_block_tb.sv
`timescale 1ns/10ps

module prv_block_tb import machine_mode_types_pkg::*, prv_pipe_pkg::*;;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int EXC_ROUNDS   = 40; // Four cycles each.
  localparam int SW_ROUNDS    = 20; // Eight cycles each.
  localparam int TEST_CYCLES  = RESET_CYCLES + 9 + EXC_ROUNDS * 4 + SW_ROUNDS * 8 + 30 + 40;

  logic        CLK, nRST;
  pipe_event_t pipe_ev;
  logic        ret, pipe_clear, soft_int, ext_int, intr;
  logic [31:0] epc, badaddr, csr_rdata;
  csr_req_t    csr_req;

  logic [31:0] lfsr_state;
  logic        seen_intr;  // intr as sampled in the last cycle.
  logic [31:0] last_rdata; // Read data from the last cycle.

  // Reference model state.
  logic        m_ie, m_latch;
  mie_t        m_mie;
  mip_t        m_mip;
  mcause_t     m_mcause;
  logic [31:0] m_mepc, m_mbadaddr, m_mtime, m_mtimecmp;

  `include "prv_tb_checks.svh"

  prv_block #(.TIMER_WIDTH(32)) u_dut (
    .CLK, .nRST, .pipe_ev, .ret, .pipe_clear, .epc, .badaddr,
    .soft_int, .ext_int, .csr_req, .intr, .csr_rdata
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(4 * TEST_CYCLES * CLK_PERIOD);
    fail_now("Timeout: the tests ran far longer than their expected length.");
  end

  // Fibonacci LFSR with taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[31]}; // One step per bit.
    end
    return r;
  endfunction

  // Highest-priority exception code. Load side comes first.
  function automatic logic [30:0] exc_code(input pipe_event_t ev);
    if (ev.fault_l) return 31'd5;
    if (ev.mal_l) return 31'd4;
    if (ev.fault_s) return 31'd7;
    if (ev.mal_s) return 31'd6;
    if (ev.breakpoint) return 31'd3;
    if (ev.env_m) return 31'd11;
    if (ev.illegal_insn) return 31'd2;
    if (ev.fault_insn) return 31'd1;
    return 31'd0;
  endfunction

  function automatic logic writes_to(input csr_addr_t a);
    return csr_req.wen && (csr_req.addr == a);
  endfunction

  function automatic logic [31:0] model_read(input csr_addr_t a);
    case (a)
      MSTATUS:  return {31'd0, m_ie};
      MIE:      return m_mie;
      MIP:      return m_mip;
      MEPC:     return m_mepc;
      MBADADDR: return m_mbadaddr;
      MTIME:    return m_mtime;
      MTIMECMP: return m_mtimecmp;
      default:  return 32'd0; // Unknown address.
    endcase
  endfunction

  task automatic model_reset();
    m_ie       = 1'b0;
    m_latch    = 1'b0;
    m_mie      = '0;
    m_mip      = '0;
    m_mcause   = '0;
    m_mepc     = '0;
    m_mbadaddr = '0;
    m_mtime    = '0;
    m_mtimecmp = '1; // Compare starts all ones.
  endtask

  task automatic idle_inputs();
    pipe_ev    = '0;
    ret        = 1'b0;
    pipe_clear = 1'b0;
    epc        = '0;
    badaddr    = '0;
    soft_int   = 1'b0;
    ext_int    = 1'b0;
    csr_req    = '0;
  endtask

  // One clock cycle. Checks at the falling edge and then advances the model.
  task automatic step();
    logic exc, fire, bad, exp_intr, timer_sel;
    @(negedge CLK);
    exc       = |pipe_ev;
    bad       = |(pipe_ev & 9'h1e7); // Faults, misalignments and illegal instruction.
    fire      = m_ie & ((m_mie.mtie & m_mip.mtip) | (m_mie.msie & m_mip.msip));
    timer_sel = m_mie.mtie & m_mip.mtip;
    exp_intr  = exc | m_latch;
    check_bit("intr", intr, exp_intr);
    seen_intr  = intr;
    last_rdata = csr_rdata;
    if (csr_req.ren) begin
      if (csr_req.addr == MCAUSE) begin
        check_mcause("csr_rdata mcause", mcause_t'(csr_rdata), m_mcause);
      end else begin
        check_word($sformatf("csr_rdata @%h", csr_req.addr), csr_rdata,
                   model_read(csr_req.addr));
      end
    end
    if (exc) m_mcause = {1'b0, exc_code(pipe_ev)};
    else if (fire) m_mcause = {1'b1, timer_sel ? 31'd7 : 31'd3};
    else if (writes_to(MCAUSE)) m_mcause = mcause_t'(csr_req.wdata);
    if (exp_intr) m_ie = 1'b0; // Trap drops the global enable.
    else if (ret) m_ie = 1'b1;
    else if (!fire && writes_to(MSTATUS)) m_ie = csr_req.wdata[0];
    if (writes_to(MIE)) begin
      m_mie      = '0;
      m_mie.mtie = csr_req.wdata[7];
      m_mie.msie = csr_req.wdata[3];
    end
    if (exc || (m_latch && pipe_clear)) m_mepc = epc;
    else if (writes_to(MEPC)) m_mepc = csr_req.wdata;
    if (bad && pipe_clear) m_mbadaddr = badaddr;
    else if (writes_to(MBADADDR)) m_mbadaddr = csr_req.wdata;
    if (writes_to(MTIMECMP)) m_mip.mtip = 1'b0;
    else if (m_mtime == m_mtimecmp) m_mip.mtip = 1'b1;
    if (soft_int || ext_int) m_mip.msip = 1'b1; // Sticky and shared by both sources.
    if (writes_to(MTIMECMP)) m_mtimecmp = csr_req.wdata;
    m_mtime = m_mtime + 32'd1;
    if (fire) m_latch = 1'b1;
    else if (pipe_clear) m_latch = 1'b0;
    @(posedge CLK);
    #1;
  endtask

  task automatic csr_access(input logic write, input csr_addr_t addr, input logic [31:0] data);
    csr_req.wen   = write;
    csr_req.ren   = !write;
    csr_req.addr  = addr;
    csr_req.wdata = data;
    step();
    csr_req = '0;
  endtask

  task automatic wait_for_intr(input int limit);
    int n;
    n = 0;
    while (!seen_intr) begin
      if (n == limit) fail_now("intr did not rise after the interrupt was raised.");
      step();
      n++;
    end
  endtask

  initial begin
    logic [31:0] r;
    int          n;
    lfsr_state = 32'hef21;
    seen_intr  = 1'b0;
    last_rdata = '0;
    idle_inputs();
    model_reset();
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    nRST = 1'b1;

    // Reset values.
    csr_access(0, MSTATUS, 0);
    csr_access(0, MIE, 0);
    csr_access(0, MIP, 0);
    csr_access(0, MCAUSE, 0);
    csr_access(0, MEPC, 0);
    csr_access(0, MBADADDR, 0);
    csr_access(0, MTIME, 0);
    csr_access(0, MTIMECMP, 0);
    csr_access(0, csr_addr_t'(12'h305), 0);

    // Random exceptions with ie clear.
    for (int i = 0; i < EXC_ROUNDS; i++) begin
      r = rand_bits(9);
      pipe_ev = (r[8:0] == 9'd0) ? 9'd1 : r[8:0]; // At least one flag.
      epc = rand_bits(32);
      badaddr = rand_bits(32);
      r = rand_bits(1);
      pipe_clear = r[0];
      step();
      idle_inputs();
      csr_access(0, MCAUSE, 0);
      csr_access(0, MEPC, 0);
      csr_access(0, MBADADDR, 0);
    end

    // Software writes and read back. MIP ignores writes.
    for (int i = 0; i < SW_ROUNDS; i++) begin
      csr_access(1, MSTATUS, rand_bits(32));
      csr_access(1, MIE, rand_bits(32));
      csr_access(1, MEPC, rand_bits(32));
      csr_access(0, MSTATUS, 0);
      csr_access(0, MIE, 0);
      csr_access(0, MEPC, 0);
      csr_access(1, MIP, rand_bits(32));
      csr_access(0, MIP, 0);
    end

    // Software or external interrupt with msie set.
    csr_access(1, MIE, 32'h8);
    csr_access(1, MSTATUS, 32'h1);
    if (rand_bits(1) != 0) soft_int = 1'b1;
    else ext_int = 1'b1;
    step();
    soft_int = 1'b0;
    ext_int  = 1'b0;
    wait_for_intr(8);
    repeat (1 + rand_bits(2)) step(); // intr must hold until pipe_clear.
    pipe_clear = 1'b1;
    epc = rand_bits(32);
    step();
    idle_inputs();
    csr_access(0, MCAUSE, 0);
    check_mcause("mcause", mcause_t'(last_rdata), {1'b1, 31'd3});
    csr_access(0, MSTATUS, 0);
    check_bit("mstatus.ie", last_rdata[0], 1'b0);
    csr_access(0, MEPC, 0);
    csr_access(1, MIE, 32'h0); // msip stays set. Mask it before returning.
    ret = 1'b1;
    step();
    ret = 1'b0;
    csr_access(0, MSTATUS, 0);
    check_bit("mstatus.ie", last_rdata[0], 1'b1);
    soft_int = 1'b1;
    step();
    soft_int = 1'b0;
    repeat (4) step(); // Masked so intr stays low.

    // Timer compare followed by a timer trap.
    csr_access(0, MTIME, 0);
    csr_access(1, MTIMECMP, last_rdata + 32'd4 + rand_bits(4));
    n = 0;
    do begin
      if (n == 40) fail_now("mip.mtip never set after the compare value was written.");
      csr_access(0, MIP, 0);
      n++;
    end while (!last_rdata[7]);
    csr_access(1, MIE, 32'h80);
    wait_for_intr(8);
    pipe_clear = 1'b1;
    step();
    pipe_clear = 1'b0;
    csr_access(0, MCAUSE, 0);
    check_mcause("mcause", mcause_t'(last_rdata), {1'b1, 31'd7});
    csr_access(1, MTIMECMP, 32'hffff_0000 | rand_bits(16));
    csr_access(0, MIP, 0);
    check_bit("mip.mtip", last_rdata[7], 1'b0);

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: sources.f
+incdir+sim
logic/machine_mode_types_pkg.sv
logic/prv_pipe_pkg.sv
logic/csr_reg.sv
logic/prv_timer.sv
logic/prv_control.sv
logic/prv_csr_file.sv
logic/prv_block.sv
sim/prv_block_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module prv_block_tb -f sources.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vprv_block_tb > sim.log 2>&1 || true
cat sim.log
grep -q "Test failures found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
